/* build.f */
+incdir+sim
hw/gf64_pkg.sv
hw/gf64_pmr_shift.sv
hw/gf64_bfly_addsub.sv
hw/gf64_final_reduce.sv
hw/gf64_shift_bfly.sv
sim/tb_gf64_shift_bfly.sv

/* hw/gf64_bfly_addsub.sv */
// Butterfly add/sub stage, aligns x with the shifted operand and forms x + t and x - t
`timescale 1ns/100ps

module gf64_bfly_addsub (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [gf64_pkg::GF64_W-1:0]    x,
  input  logic [gf64_pkg::PMR_OUT_W-1:0] t,
  input  logic                          t_avail,
  output logic [gf64_pkg::SUM_W-1:0]     sum,
  output logic [gf64_pkg::SUM_W-1:0]     diff,
  output logic                          sd_avail
);

  import gf64_pkg::*;

  // ----------------------------------------
  // x alignment
  // ----------------------------------------

  // x enters with y, t shows up PMR_LAT cycles later
  logic [PMR_LAT-1:0][GF64_W-1:0] x_dly;

  always_ff @(posedge clk) begin
    x_dly[0] <= x;
    for (int i = 1; i < PMR_LAT; i++) begin
      x_dly[i] <= x_dly[i-1];
    end
  end

  // ----------------------------------------
  // Sum and difference
  // ----------------------------------------

  // x is canonical so it is unsigned
  logic [SUM_W-1:0] x_ext;
  // t is two's complement
  logic [SUM_W-1:0] t_ext;

  assign x_ext = {{(SUM_W-GF64_W){1'b0}}, x_dly[PMR_LAT-1]};
  assign t_ext = {{(SUM_W-PMR_OUT_W){t[PMR_OUT_W-1]}}, t};

  logic [SUM_W-1:0] sum_q;
  logic [SUM_W-1:0] diff_q;
  logic             avail_q;

  always_ff @(posedge clk) begin
    sum_q  <= x_ext + t_ext;
    diff_q <= x_ext - t_ext;
  end

  // Valid bit travels beside the data
  always_ff @(posedge clk) begin
    if (rst) begin
      avail_q <= 1'b0;
    end else begin
      avail_q <= t_avail;
    end
  end

  assign sum      = sum_q;
  assign diff     = diff_q;
  assign sd_avail = avail_q;

endmodule

/* hw/gf64_final_reduce.sv */
// Final reduction of a signed 67-bit value to the canonical range [0, p)
`timescale 1ns/100ps

module gf64_final_reduce (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [gf64_pkg::SUM_W-1:0] a,
  input  logic                      in_avail,
  output logic [gf64_pkg::GF64_W-1:0] r,
  output logic                      out_avail
);

  import gf64_pkg::*;

  // ----------------------------------------
  // Multiples of p
  // ----------------------------------------

  // One bit above SUM_W so that a + 4p never wraps
  logic [SUM_W:0]  p4;
  logic [SUM_W:0]  p2;
  // Stage 2 only needs 65 bits
  logic [GF64_W:0] p1;

  assign p4 = {{(SUM_W-GF64_W-1){1'b0}}, GF64_P, 2'b00};
  assign p2 = {{(SUM_W-GF64_W){1'b0}}, GF64_P, 1'b0};
  assign p1 = {1'b0, GF64_P};

  // ----------------------------------------
  // Stage 1, coarse correction
  // ----------------------------------------
  logic [SUM_W:0] s1_ext;
  logic [SUM_W:0] s1_pos;
  logic [SUM_W:0] s1_lt4;
  logic [SUM_W:0] s1_lt2;

  // Sign extension then offset by 4p, result lies in [0, 8p)
  assign s1_ext = {a[SUM_W-1], a};
  assign s1_pos = s1_ext + p4;

  // Now below 4p
  assign s1_lt4 = (s1_pos >= p4) ? s1_pos - p4 : s1_pos;

  // Now below 2p
  assign s1_lt2 = (s1_lt4 >= p2) ? s1_lt4 - p2 : s1_lt4;

  // 2p fits in 65 bits
  logic [GF64_W:0] s1_q;
  logic            s1_avail;

  always_ff @(posedge clk) begin
    s1_q <= s1_lt2[GF64_W:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_avail <= 1'b0;
    end else begin
      s1_avail <= in_avail;
    end
  end

  // ----------------------------------------
  // Stage 2, fine correction
  // ----------------------------------------
  logic [GF64_W:0]   s2_lt1;
  logic [GF64_W-1:0] s2_q;
  logic              s2_avail;

  // One conditional subtract gives the canonical value
  assign s2_lt1 = (s1_q >= p1) ? s1_q - p1 : s1_q;

  always_ff @(posedge clk) begin
    s2_q <= s2_lt1[GF64_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_avail <= 1'b0;
    end else begin
      s2_avail <= s1_avail;
    end
  end

  assign r         = s2_q;
  assign out_avail = s2_avail;

endmodule

/* hw/gf64_pkg.sv */
// Goldilocks field constants, datapath widths and pipeline latencies for the shift butterfly
package gf64_pkg;

  // ----------------------------------------
  // Field
  // ----------------------------------------

  // Field width and prime p = 2^64 - 2^32 + 1
  localparam int GF64_W = 64;
  localparam logic [GF64_W-1:0] GF64_P = 64'hFFFF_FFFF_0000_0001;

  // Chunk size used by the folding reduction
  // 2^64 = 2^32 - 1 and 2^96 = -1 modulo p
  localparam int GF64_MID_W = GF64_W / 2;

  // ----------------------------------------
  // Datapath widths
  // ----------------------------------------

  // Shifter operand: field width, one carry bit, one sign bit
  localparam int PMR_OP_W = GF64_W + 2;

  // Shifter output, two's complement partial result
  localparam int PMR_OUT_W = GF64_W + 2;

  // Shift amount, supports s in [0, 94]
  localparam int SHIFT_W = 7;

  // Add/sub result, two's complement
  localparam int SUM_W = PMR_OUT_W + 1;

  // ----------------------------------------
  // Latencies
  // ----------------------------------------

  // Input reg, chunk reg, output reg
  localparam int PMR_LAT = 3;

  // Single registered add/sub
  localparam int ADDSUB_LAT = 1;

  // Coarse then fine subtraction
  localparam int REDUCE_LAT = 2;

  // in_avail to out_avail at the top level
  localparam int BFLY_LAT = PMR_LAT + ADDSUB_LAT + REDUCE_LAT;

endpackage

/* hw/gf64_pmr_shift.sv */
// Signed shift by a power of two with partial reduction modulo the Goldilocks prime
`timescale 1ns/100ps

module gf64_pmr_shift (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_avail,
  input  logic [gf64_pkg::PMR_OP_W-1:0]  a,
  input  logic [gf64_pkg::SHIFT_W-1:0]   s,
  input  logic                          s_sign,
  output logic [gf64_pkg::PMR_OUT_W-1:0] z,
  output logic                          out_avail
);

  import gf64_pkg::*;

  // Operand after the sub-chunk shift, max shift is MID_W-1
  localparam int SHIFTED_W = PMR_OP_W + GF64_MID_W - 1;
  // Five chunks hold any operand shifted by up to 94
  localparam int EXT_W = 5 * GF64_MID_W;
  // Bits selecting s mod 32
  localparam int SUB_W = $clog2(GF64_MID_W);

  // ----------------------------------------
  // Stage 0, input register
  // ----------------------------------------
  logic [PMR_OP_W-1:0] s0_a;
  logic [SHIFT_W-1:0]  s0_s;
  logic                s0_s_sign;
  logic                s0_avail;

  always_ff @(posedge clk) begin
    s0_a      <= a;
    s0_s      <= s;
    s0_s_sign <= s_sign;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s0_avail <= 1'b0;
    end else begin
      s0_avail <= in_avail;
    end
  end

  // Conditional two's complement negation
  logic [PMR_OP_W-1:0] s0_a_neg;
  assign s0_a_neg = (s0_a ^ {PMR_OP_W{s0_s_sign}}) + PMR_OP_W'(s0_s_sign);

  // Shift within a chunk by s mod 32, keeping the sign
  logic [SUB_W-1:0]              s0_sub_shift;
  logic [SHIFTED_W-1:0]          s0_shifted;
  logic [4:0][GF64_MID_W-1:0]    s0_ext;
  logic [4:0][GF64_MID_W-1:0]    s0_chunks;

  assign s0_sub_shift = s0_s[SUB_W-1:0];
  assign s0_shifted   = {{(GF64_MID_W-1){s0_a_neg[PMR_OP_W-1]}}, s0_a_neg} << s0_sub_shift;
  assign s0_ext       = {{(EXT_W-SHIFTED_W){s0_shifted[SHIFTED_W-1]}}, s0_shifted};

  // Whole chunk moves for s >= 32 and s >= 64
  always_comb begin
    if (s0_s < SHIFT_W'(GF64_MID_W)) begin
      s0_chunks = s0_ext;
    end else if (s0_s < SHIFT_W'(2 * GF64_MID_W)) begin
      s0_chunks = {s0_ext[3:0], {GF64_MID_W{1'b0}}};
    end else begin
      s0_chunks = {s0_ext[2:0], {(2 * GF64_MID_W){1'b0}}};
    end
  end

  // ----------------------------------------
  // Stage 1, chunk fold
  // ----------------------------------------
  logic [4:0][GF64_MID_W-1:0] s1_chunks;
  logic                       s1_avail;

  always_ff @(posedge clk) begin
    s1_chunks <= s0_chunks;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_avail <= 1'b0;
    end else begin
      s1_avail <= s0_avail;
    end
  end

  // Value = c0 + c1*2^32 + c2*2^64 + c3*2^96 + c4*2^128, c4 signed
  // c2*2^64 becomes c2*2^32 - c2
  // c3*2^96 becomes -c3
  // c4*2^128 becomes -c4*2^32, the sign bit of c4 adds back 2^63
  logic [PMR_OUT_W-1:0] s1_low;
  logic [PMR_OUT_W-1:0] s1_c2_hi;
  logic [PMR_OUT_W-1:0] s1_c2_lo;
  logic [PMR_OUT_W-1:0] s1_top;
  logic [PMR_OUT_W-1:0] s1_top_sign;
  logic [PMR_OUT_W-1:0] s1_z;

  assign s1_low      = PMR_OUT_W'({s1_chunks[1], s1_chunks[0]});
  assign s1_c2_hi    = PMR_OUT_W'({s1_chunks[2], {GF64_MID_W{1'b0}}});
  assign s1_c2_lo    = PMR_OUT_W'(s1_chunks[2]);
  assign s1_top      = PMR_OUT_W'({s1_chunks[4][GF64_MID_W-2:0], s1_chunks[3]});
  assign s1_top_sign = PMR_OUT_W'({s1_chunks[4][GF64_MID_W-1], {(GF64_W-1){1'b0}}});

  // Signed partial result, congruent to +/- a * 2^s
  assign s1_z = s1_low + s1_c2_hi - s1_c2_lo - s1_top + s1_top_sign;

  // ----------------------------------------
  // Stage 2, output register
  // ----------------------------------------
  logic [PMR_OUT_W-1:0] s2_z;
  logic                 s2_avail;

  always_ff @(posedge clk) begin
    s2_z <= s1_z;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_avail <= 1'b0;
    end else begin
      s2_avail <= s1_avail;
    end
  end

  assign z         = s2_z;
  assign out_avail = s2_avail;

endmodule

/* hw/gf64_shift_bfly.sv */
// Radix-2 NTT butterfly over GF(p) with a signed power-of-two twiddle, u = x + w*y, v = x - w*y
`timescale 1ns/100ps

module gf64_shift_bfly (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_avail,
  input  logic [gf64_pkg::GF64_W-1:0]  x,
  input  logic [gf64_pkg::GF64_W-1:0]  y,
  input  logic [gf64_pkg::SHIFT_W-1:0] s,
  input  logic                        s_sign,
  output logic [gf64_pkg::GF64_W-1:0]  u,
  output logic [gf64_pkg::GF64_W-1:0]  v,
  output logic                        out_avail
);

  import gf64_pkg::*;

  // ----------------------------------------
  // Twiddle product, w*y
  // ----------------------------------------
  logic [PMR_OUT_W-1:0] t;
  logic                 t_avail;

  // y is canonical, zero-extend to the operand width
  gf64_pmr_shift gf64_pmr_shift_inst (
    .clk       (clk),
    .rst       (rst),
    .in_avail  (in_avail),
    .a         ({{(PMR_OP_W-GF64_W){1'b0}}, y}),
    .s         (s),
    .s_sign    (s_sign),
    .z         (t),
    .out_avail (t_avail)
  );

  // ----------------------------------------
  // Butterfly sum and difference
  // ----------------------------------------
  logic [SUM_W-1:0] sum;
  logic [SUM_W-1:0] diff;
  logic             sd_avail;

  // x is delayed inside to meet t
  gf64_bfly_addsub gf64_bfly_addsub_inst (
    .clk      (clk),
    .rst      (rst),
    .x        (x),
    .t        (t),
    .t_avail  (t_avail),
    .sum      (sum),
    .diff     (diff),
    .sd_avail (sd_avail)
  );

  // ----------------------------------------
  // Canonical outputs
  // ----------------------------------------
  gf64_final_reduce gf64_final_reduce_u_inst (
    .clk       (clk),
    .rst       (rst),
    .a         (sum),
    .in_avail  (sd_avail),
    .r         (u),
    .out_avail (out_avail)
  );

  // Same avail timing as the u reducer, so its strobe is not needed
  gf64_final_reduce gf64_final_reduce_v_inst (
    .clk       (clk),
    .rst       (rst),
    .a         (diff),
    .in_avail  (sd_avail),
    .r         (v),
    .out_avail ()
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the butterfly testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_gf64_shift_bfly \
  -f build.f

./obj_dir/Vtb_gf64_shift_bfly > sim.log
cat sim.log

if grep -qx "Everything OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation reported errors"
  exit 1
fi

/* sim/tb_gf64_model.svh */
// Reference model of Goldilocks field arithmetic used by the butterfly checks
`ifndef TB_GF64_MODEL_SVH
`define TB_GF64_MODEL_SVH

// Canonical a + b mod p, inputs already canonical
function automatic logic [GF64_W-1:0] add_mod_p(input logic [GF64_W-1:0] a,
                                                input logic [GF64_W-1:0] b);
  logic [GF64_W:0] total;
  total = {1'b0, a} + {1'b0, b};
  if (total >= {1'b0, GF64_P}) begin
    total = total - {1'b0, GF64_P};
  end
  return total[GF64_W-1:0];
endfunction

// Canonical a - b mod p
function automatic logic [GF64_W-1:0] sub_mod_p(input logic [GF64_W-1:0] a,
                                                input logic [GF64_W-1:0] b);
  if (a >= b) begin
    return a - b;
  end
  // Borrow case, a + p - b stays below p
  return a + (GF64_P - b);
endfunction

// +/- 2^sh * y mod p by repeated doubling
function automatic logic [GF64_W-1:0] mul_by_twiddle(input logic [GF64_W-1:0] y,
                                                     input logic [SHIFT_W-1:0] sh,
                                                     input logic neg);
  logic [GF64_W-1:0] acc;
  acc = y;
  for (int i = 0; i < int'(sh); i++) begin
    acc = add_mod_p(acc, acc);
  end
  // Negation keeps zero at zero
  if (neg && acc != '0) begin
    acc = GF64_P - acc;
  end
  return acc;
endfunction

`endif

/* sim/tb_gf64_shift_bfly.sv */
// Testbench for the shift butterfly that checks directed and random pairs against a field model
`timescale 1ns/100ps

module tb_gf64_shift_bfly;

  import gf64_pkg::*;

  `include "tb_gf64_model.svh"

  // Longest wait for an output strobe
  localparam int TIMEOUT_CYCLES = 20;

  logic               clk;
  logic               rst;
  logic               in_avail;
  logic               s_sign;
  logic               out_avail;
  logic [GF64_W-1:0]  x;
  logic [GF64_W-1:0]  y;
  logic [GF64_W-1:0]  u;
  logic [GF64_W-1:0]  v;
  logic [SHIFT_W-1:0] s;

  int seed = 32'hf92c_1897;
  int err_count = 0;
  int check_count = 0;
  int test_count = 0;

  gf64_shift_bfly gf64_shift_bfly_inst (
    .clk       (clk),
    .rst       (rst),
    .in_avail  (in_avail),
    .x         (x),
    .y         (y),
    .s         (s),
    .s_sign    (s_sign),
    .u         (u),
    .v         (v),
    .out_avail (out_avail)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Uniform-ish random element below p
  function automatic logic [GF64_W-1:0] rand_field();
    logic [GF64_W-1:0] r;
    r = {$random(seed), $random(seed)};
    if (r >= GF64_P) r = r - GF64_P;
    return r;
  endfunction

  // Value compare with canonical range check
  task automatic compare_word(input string name, input string what,
                              input logic [GF64_W-1:0] exp, input logic [GF64_W-1:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
      err_count++;
    end
    assert (act < GF64_P) else begin
      $display("%s: %s = %h is not a canonical field element", name, what, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    test_count++;
    $display("%s finished with %0d errors", name, err_count - start_err);
  endtask

  // One isolated pair with latency counted from the sampling edge
  task automatic send_pair_and_check(input string name, input logic [GF64_W-1:0] xv,
                                     input logic [GF64_W-1:0] yv,
                                     input logic [SHIFT_W-1:0] sv, input logic sg);
    logic [GF64_W-1:0] wy;
    int cycles;
    bit seen;
    wy = mul_by_twiddle(yv, sv, sg);
    @(posedge clk);
    in_avail <= 1'b1;
    x <= xv;
    y <= yv;
    s <= sv;
    s_sign <= sg;
    // The DUT samples the pair on this edge
    @(posedge clk);
    in_avail <= 1'b0;
    cycles = 0;
    seen = 0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      seen = (out_avail === 1'b1);
    end
    assert (seen) else begin
      $display("%s: out_avail never rose within %0d cycles", name, TIMEOUT_CYCLES);
      err_count++;
    end
    if (seen) begin
      assert (cycles == BFLY_LAT) else begin
        $display("FAIL %s latency expected %0d actual %0d", name, BFLY_LAT, cycles);
        err_count++;
      end
      compare_word(name, "u", add_mod_p(xv, wy), u);
      compare_word(name, "v", sub_mod_p(xv, wy), v);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  // Reset held 10 cycles followed by 10 idle cycles
  task automatic reset_idle_check();
    int start_err;
    start_err = err_count;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      if (i == 9) rst <= 1'b0;
      @(negedge clk);
      assert (out_avail === 1'b0) else begin
        $display("reset_idle: out_avail not low in idle cycle %0d", i);
        err_count++;
      end
    end
    report_test("reset_idle", start_err);
  endtask

  // Shifts at chunk boundaries with both signs
  task automatic single_pair_sweep();
    logic [SHIFT_W-1:0] s_list [7] = '{7'd0, 7'd1, 7'd31, 7'd32, 7'd63, 7'd64, 7'd94};
    int start_err;
    start_err = err_count;
    foreach (s_list[i]) begin
      for (int sg = 0; sg < 2; sg++) begin
        send_pair_and_check("single_pair", rand_field(), rand_field(), s_list[i], sg[0]);
      end
    end
    report_test("single_pair", start_err);
  endtask

  // Corner operands crossed with several shifts and alternating signs
  task automatic edge_operand_sweep();
    logic [GF64_W-1:0] vals [5];
    logic [SHIFT_W-1:0] s_list [5] = '{7'd0, 7'd17, 7'd32, 7'd64, 7'd94};
    int start_err;
    start_err = err_count;
    vals = '{64'd0, 64'd1, GF64_P - 64'd1, 64'h1_0000_0000, 64'h8000_0000_0000_0000};
    foreach (vals[i]) begin
      foreach (vals[j]) begin
        foreach (s_list[k]) begin
          send_pair_and_check("edge_operands", vals[i], vals[j], s_list[k], k[0]);
        end
      end
    end
    report_test("edge_operands", start_err);
  endtask

  // Random stream where max_gap 0 gives back-to-back pairs
  task automatic stream_random_pairs(input string name, input int n_pairs, input int max_gap);
    logic [GF64_W-1:0] exp_u_q [$];
    logic [GF64_W-1:0] exp_v_q [$];
    logic [GF64_W-1:0] xv;
    logic [GF64_W-1:0] yv;
    logic [GF64_W-1:0] wy;
    logic [SHIFT_W-1:0] sv;
    logic [31:0] r32;
    int sent;
    int seen;
    int idle;
    int gap;
    int start_err;
    start_err = err_count;
    sent = 0;
    seen = 0;
    idle = 0;
    gap = 0;
    while ((sent < n_pairs || exp_u_q.size() > 0) && idle < TIMEOUT_CYCLES) begin
      @(posedge clk);
      if (sent < n_pairs && gap == 0) begin
        xv = rand_field();
        yv = rand_field();
        sv = SHIFT_W'($unsigned($random(seed)) % 95);
        r32 = $random(seed);
        wy = mul_by_twiddle(yv, sv, r32[0]);
        // Results return in input order
        exp_u_q.push_back(add_mod_p(xv, wy));
        exp_v_q.push_back(sub_mod_p(xv, wy));
        in_avail <= 1'b1;
        x <= xv;
        y <= yv;
        s <= sv;
        s_sign <= r32[0];
        sent++;
        gap = int'($unsigned($random(seed)) % (max_gap + 1));
      end else begin
        in_avail <= 1'b0;
        if (gap > 0) gap--;
      end
      // Outputs settle well before the falling edge
      @(negedge clk);
      if (out_avail === 1'b1) begin
        seen++;
        idle = 0;
        assert (exp_u_q.size() > 0) else begin
          $display("%s: out_avail pulsed with no pair outstanding", name);
          err_count++;
        end
        if (exp_u_q.size() > 0) begin
          compare_word(name, "u", exp_u_q.pop_front(), u);
          compare_word(name, "v", exp_v_q.pop_front(), v);
        end
      end else begin
        idle++;
      end
    end
    assert (idle < TIMEOUT_CYCLES) else begin
      $display("%s: timed out with %0d results outstanding", name, exp_u_q.size());
      err_count++;
    end
    @(posedge clk);
    in_avail <= 1'b0;
    // Pipeline must stay quiet once drained
    repeat (10) begin
      @(negedge clk);
      if (out_avail === 1'b1) seen++;
    end
    assert (seen == n_pairs) else begin
      $display("FAIL %s out_avail cycles expected %0d actual %0d", name, n_pairs, seen);
      err_count++;
    end
    report_test(name, start_err);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst <= 1'b1;
    in_avail <= 1'b0;
    x <= '0;
    y <= '0;
    s <= '0;
    s_sign <= 1'b0;
    reset_idle_check();
    single_pair_sweep();
    edge_operand_sweep();
    stream_random_pairs("back_to_back", 200, 0);
    stream_random_pairs("gapped_stream", 150, 3);
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
